//--- rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// address and data word width
`define RV_XLEN 32

// fetch queue entries
`define RV_QUEUE_DEPTH 4

// packets that may still reach the queue after a fetch start
`define RV_FETCH_INFLIGHT 2

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif

//--- rv_bus_pkg.sv
`include "rv_macros.svh"

package rv_bus_pkg;

    // request toward instruction memory
    typedef struct packed
    {
        logic                cyc;   // level, high while a word is wanted
        logic [`RV_XLEN-1:0] addr;  // byte address of the word
    } bus_req_t;

    // response from instruction memory
    typedef struct packed
    {
        logic                ack;   // one pulse per word
        logic [`RV_XLEN-1:0] data;
    } bus_rsp_t;

endpackage

//--- rv_instr_pkg.sv
`include "rv_macros.svh"

package rv_instr_pkg;

    // aligned instruction as it leaves the aligner
    typedef struct packed
    {
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] instr;  // low half holds the first parcel
    } fetch_pkt_t;

    typedef enum logic [2:0]
    {
        cls_alu     = 3'd0,
        cls_load    = 3'd1,
        cls_store   = 3'd2,
        cls_branch  = 3'd3,
        cls_jump    = 3'd4,
        cls_system  = 3'd5,
        cls_illegal = 3'd6
    } instr_class_t;

    // record handed to the decode stage
    typedef struct packed
    {
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] instr;       // upper half zero when compressed
        logic                compressed;
        instr_class_t        cls;
    } predec_t;

endpackage

//--- rv_pc_gen.sv
`timescale 1ns/1ps

`include "rv_macros.svh"

module rv_pc_gen
(
    input  logic                                 i_clk,
    input  logic                                 i_reset_n,
    input  logic                                 i_move,
    input  logic [`RV_XLEN-1:0]                  i_pc_incr,
    input  logic                                 i_redirect,
    input  logic [`RV_XLEN-1:0]                  i_redirect_pc,
    input  logic [$clog2(`RV_QUEUE_DEPTH+1)-1:0] i_queue_count,
    output logic [`RV_XLEN-1:0]                  o_pc,
    output logic                                 o_start,
    output logic                                 o_pc_select
);

    logic [`RV_XLEN-1:0] pc;
    logic                busy;        // a fetch is out, waiting for move
    logic                pc_fresh;    // pc changed last edge, bus address lags
    logic                queue_room;

    assign queue_room = (int'(i_queue_count) + `RV_FETCH_INFLIGHT) <= `RV_QUEUE_DEPTH;

    // one fetch at a time, and only once the address register has caught up
    assign o_start = queue_room && !busy && !pc_fresh && !i_redirect;
    assign o_pc_select = i_redirect;
    assign o_pc = pc;

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            pc <= `RV_RESET_PC;
        else if (i_redirect)
            pc <= i_redirect_pc;
        else if (i_move)
            pc <= pc + i_pc_incr;
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n || i_redirect)
            busy <= 1'b0;              // aligner drops the old fetch
        else if (o_start)
            busy <= 1'b1;
        else if (i_move)
            busy <= 1'b0;
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            pc_fresh <= 1'b1;
        else
            pc_fresh <= i_redirect || i_move;
    end

endmodule

//--- rv_fetch_aligner.sv
`timescale 1ns/1ps

`include "rv_macros.svh"

module rv_fetch_aligner
(
    input  logic                i_clk,
    input  logic                i_reset_n,
    input  logic [`RV_XLEN-1:0] i_pc,
    input  logic                i_start,
    input  logic                i_pc_select,
    input  logic [`RV_XLEN-1:0] i_instruction,
    input  logic                i_ack,
    output logic                o_cyc,
    output logic                o_move,
    output logic [`RV_XLEN-1:0] o_pc_incr,
    output logic [`RV_XLEN-1:0] o_addr,
    output logic                o_ready,
    output logic [`RV_XLEN-1:0] o_pc,
    output logic [`RV_XLEN-1:0] o_instruction
);

    logic                bus_cyc;
    logic                misal;        // low word of a straddling pc requested
    logic                misal_prev;   // current ack carries the upper parcel
    logic                second_word;
    logic                instr_ready;
    logic [15:0]         prev_hi;      // high halfword of the last word seen
    logic [`RV_XLEN-1:0] instr_mux;
    logic [`RV_XLEN-1:0] fetch_addr;
    logic                ready;
    logic [`RV_XLEN-1:0] pc_q;
    logic [`RV_XLEN-1:0] instr_q;

    // a redirect stops requests and swallows the ack that is due
    assign bus_cyc = (i_start || misal) && !i_pc_select;
    assign second_word = bus_cyc && !misal && i_pc[1];
    assign instr_ready = i_ack && !(misal && i_pc[1]) && !i_pc_select;

    // address register runs one cycle behind the pc
    always_ff @(posedge i_clk)
    begin
        fetch_addr <= i_pc + {{(`RV_XLEN-3){1'b0}}, second_word, 2'b00};
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n || i_pc_select)
            misal <= 1'b0;
        else if (bus_cyc && i_pc[1])
            misal <= !misal;
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n || i_pc_select)
            misal_prev <= 1'b0;
        else
            misal_prev <= misal;
    end

    always_ff @(posedge i_clk)
    begin
        if (i_ack)
            prev_hi <= i_instruction[31:16];
    end

    // straddling case joins the old high half with the new low half
    assign instr_mux = misal_prev ? {i_instruction[15:0], prev_hi} : i_instruction;

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            ready <= 1'b0;
        else
            ready <= instr_ready;
    end

    always_ff @(posedge i_clk)
    begin
        if (instr_ready)
        begin
            pc_q <= i_pc;
            instr_q <= instr_mux;
        end
    end

    assign o_cyc = bus_cyc;
    assign o_move = instr_ready || i_pc_select;
    assign o_pc_incr = (instr_mux[1:0] == 2'b11) ? `RV_XLEN'(4) : `RV_XLEN'(2);
    assign o_addr = {fetch_addr[`RV_XLEN-1:2], 2'b00};
    assign o_ready = ready;
    assign o_pc = pc_q;
    assign o_instruction = instr_q;

endmodule

//--- rv_fetch_queue.sv
`timescale 1ns/1ps

`include "rv_macros.svh"

module rv_fetch_queue
(
    input  logic                                 i_clk,
    input  logic                                 i_reset_n,
    input  logic                                 i_flush,
    input  logic                                 i_push,
    input  rv_instr_pkg::fetch_pkt_t             i_pkt,
    input  logic                                 i_pop,
    output rv_instr_pkg::fetch_pkt_t             o_pkt,
    output logic                                 o_not_empty,
    output logic [$clog2(`RV_QUEUE_DEPTH+1)-1:0] o_count
);

    localparam int DEPTH = `RV_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    rv_instr_pkg::fetch_pkt_t mem [DEPTH];
    logic [PTR_W-1:0]         rd_ptr;
    logic [PTR_W-1:0]         wr_ptr;
    logic [CNT_W-1:0]         count;
    logic                     full;
    logic                     rd_en;
    logic                     wr_en;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    assign full = (count == CNT_W'(DEPTH));
    assign rd_en = i_pop && o_not_empty;
    assign wr_en = i_push && (!full || rd_en);

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n || i_flush)
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;               // flush beats a push in the same cycle
        end
        else
        begin
            if (wr_en)
                wr_ptr <= ptr_next(wr_ptr);
            if (rd_en)
                rd_ptr <= ptr_next(rd_ptr);
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (wr_en)
            mem[wr_ptr] <= i_pkt;
    end

    assign o_pkt = mem[rd_ptr];        // head is visible before the pop
    assign o_not_empty = (count != '0);
    assign o_count = count;

endmodule

//--- rv_predecode.sv
`timescale 1ns/1ps

`include "rv_macros.svh"

module rv_predecode
(
    input  logic                     i_clk,
    input  logic                     i_reset_n,
    input  logic                     i_flush,
    input  logic                     i_take,
    input  logic                     i_not_empty,
    input  rv_instr_pkg::fetch_pkt_t i_pkt,
    output logic                     o_pop,
    output logic                     o_valid,
    output rv_instr_pkg::predec_t    o_rec
);

    logic                  compressed;
    logic                  valid;
    rv_instr_pkg::predec_t rec;

    function automatic rv_instr_pkg::instr_class_t classify(input logic [`RV_XLEN-1:0] instr);
        rv_instr_pkg::instr_class_t cls;
        cls = rv_instr_pkg::cls_illegal;
        if (instr[1:0] == 2'b11)
        begin
            case (instr[6:2])
                5'b01100, 5'b00100, 5'b01101, 5'b00101: cls = rv_instr_pkg::cls_alu;
                5'b00000:           cls = rv_instr_pkg::cls_load;
                5'b01000:           cls = rv_instr_pkg::cls_store;
                5'b11000:           cls = rv_instr_pkg::cls_branch;
                5'b11011, 5'b11001: cls = rv_instr_pkg::cls_jump;    // jal, jalr
                5'b11100, 5'b00011: cls = rv_instr_pkg::cls_system;  // also fence
                default:            cls = rv_instr_pkg::cls_illegal;
            endcase
        end
        else
        begin
            // quadrant, then funct3
            case ({instr[1:0], instr[15:13]})
                5'b00_000: cls = (instr[15:0] == 16'h0000) ? rv_instr_pkg::cls_illegal
                                                            : rv_instr_pkg::cls_alu;
                5'b00_010: cls = rv_instr_pkg::cls_load;
                5'b00_110: cls = rv_instr_pkg::cls_store;
                5'b01_001, 5'b01_101: cls = rv_instr_pkg::cls_jump;    // c.jal, c.j
                5'b01_110, 5'b01_111: cls = rv_instr_pkg::cls_branch;
                5'b01_000, 5'b01_010, 5'b01_011, 5'b01_100: cls = rv_instr_pkg::cls_alu;
                5'b10_000: cls = rv_instr_pkg::cls_alu;                 // c.slli
                5'b10_010: cls = rv_instr_pkg::cls_load;
                5'b10_110: cls = rv_instr_pkg::cls_store;
                5'b10_100:
                begin
                    if (instr[6:2] != 5'd0)
                        cls = rv_instr_pkg::cls_alu;                   // c.mv, c.add
                    else if (instr[12] && instr[11:7] == 5'd0)
                        cls = rv_instr_pkg::cls_system;                // c.ebreak
                    else
                        cls = rv_instr_pkg::cls_jump;                  // c.jr, c.jalr
                end
                default:   cls = rv_instr_pkg::cls_illegal;            // float forms
            endcase
        end
        return cls;
    endfunction

    assign o_pop = i_take && i_not_empty && !i_flush;
    assign compressed = (i_pkt.instr[1:0] != 2'b11);

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n || i_flush)
            valid <= 1'b0;
        else
            valid <= o_pop;
    end

    always_ff @(posedge i_clk)
    begin
        if (o_pop)
        begin
            rec.pc <= i_pkt.pc;
            rec.instr <= compressed ? {16'h0000, i_pkt.instr[15:0]} : i_pkt.instr;
            rec.compressed <= compressed;
            rec.cls <= classify(i_pkt.instr);
        end
    end

    assign o_valid = valid;
    assign o_rec = rec;

endmodule

//--- rv_fetch_top.sv
`timescale 1ns/1ps

`include "rv_macros.svh"

module rv_fetch_top
(
    input  logic                       i_clk,
    input  logic                       i_reset_n,
    input  logic                       i_redirect,
    input  logic [`RV_XLEN-1:0]        i_redirect_pc,
    input  logic                       i_take,
    input  rv_bus_pkg::bus_rsp_t       i_bus_rsp,
    output wire rv_bus_pkg::bus_req_t  o_bus_req,
    output logic                       o_valid,
    output rv_instr_pkg::predec_t      o_rec
);

    logic [`RV_XLEN-1:0]                  fetch_pc;
    logic [`RV_XLEN-1:0]                  pc_incr;
    logic                                 start;
    logic                                 pc_select;
    logic                                 move;
    logic                                 push;
    logic                                 pop;
    logic                                 not_empty;
    logic [$clog2(`RV_QUEUE_DEPTH+1)-1:0] queue_count;
    wire rv_instr_pkg::fetch_pkt_t        push_pkt;
    rv_instr_pkg::fetch_pkt_t             head_pkt;

    rv_pc_gen u_pc_gen
    (
        .i_clk         (i_clk),
        .i_reset_n     (i_reset_n),
        .i_move        (move),
        .i_pc_incr     (pc_incr),
        .i_redirect    (i_redirect),
        .i_redirect_pc (i_redirect_pc),
        .i_queue_count (queue_count),
        .o_pc          (fetch_pc),
        .o_start       (start),
        .o_pc_select   (pc_select)
    );

    rv_fetch_aligner u_aligner
    (
        .i_clk         (i_clk),
        .i_reset_n     (i_reset_n),
        .i_pc          (fetch_pc),
        .i_start       (start),
        .i_pc_select   (pc_select),
        .i_instruction (i_bus_rsp.data),
        .i_ack         (i_bus_rsp.ack),
        .o_cyc         (o_bus_req.cyc),
        .o_move        (move),
        .o_pc_incr     (pc_incr),
        .o_addr        (o_bus_req.addr),
        .o_ready       (push),
        .o_pc          (push_pkt.pc),
        .o_instruction (push_pkt.instr)
    );

    rv_fetch_queue u_queue
    (
        .i_clk       (i_clk),
        .i_reset_n   (i_reset_n),
        .i_flush     (i_redirect),
        .i_push      (push),
        .i_pkt       (push_pkt),
        .i_pop       (pop),
        .o_pkt       (head_pkt),
        .o_not_empty (not_empty),
        .o_count     (queue_count)
    );

    rv_predecode u_predecode
    (
        .i_clk       (i_clk),
        .i_reset_n   (i_reset_n),
        .i_flush     (i_redirect),
        .i_take      (i_take),
        .i_not_empty (not_empty),
        .i_pkt       (head_pkt),
        .o_pop       (pop),
        .o_valid     (o_valid),
        .o_rec       (o_rec)
    );

endmodule

//--- tb_rv_fetch.sv
`timescale 1ns/1ps

`include "rv_macros.svh"

module tb_rv_fetch;

    localparam int num_records = 600;
    localparam int cycle_limit = 8 * num_records + 200;
    localparam int image_halves = 512;   // 256 words of instruction memory

    logic                  clk = 1'b0;
    logic                  reset_n;
    logic                  redirect;
    logic [`RV_XLEN-1:0]   redirect_pc;
    logic                  take;
    rv_bus_pkg::bus_rsp_t  bus_rsp;
    rv_bus_pkg::bus_req_t  bus_req;
    logic                  valid;
    rv_instr_pkg::predec_t rec;

    logic [15:0]         halves [image_halves];
    logic [31:0]         image [image_halves / 2];
    logic [`RV_XLEN-1:0] exp_pc;           // model pc of the next record
    logic                next_ack;
    logic [31:0]         next_data;
    logic                next_take;
    logic                next_redirect;
    logic [`RV_XLEN-1:0] next_redirect_pc;
    int                  received = 0;
    int                  cycle_count = 0;
    int                  stall_left = 0;
    int                  take_low_run = 0;
    int                  straddles = 0;
    int                  zero_halves = 0;
    int                  redirects = 0;
    int                  idle_checks = 0;

    rv_fetch_top u_rv_fetch_top
    (
        .i_clk         (clk),
        .i_reset_n     (reset_n),
        .i_redirect    (redirect),
        .i_redirect_pc (redirect_pc),
        .i_take        (take),
        .i_bus_rsp     (bus_rsp),
        .o_bus_req     (bus_req),
        .o_valid       (valid),
        .o_rec         (rec)
    );

    always #10 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit)
        begin
            $display("Timeout after %0d cycles, %0d of %0d records arrived",
                     cycle_count, received, num_records);
            $display("Errors found");
            $fatal(1, "run stopped at the cycle limit");
        end
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("Error at %0t: %s got %h expected %h", $time, what, got, exp);
            $display("Errors found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    function automatic logic [31:0] full_encoding();
        logic [31:0] bits;
        logic [6:0]  opcode;
        bits = $urandom();
        case ($urandom() % 13)
            0:       opcode = 7'b0110011;
            1:       opcode = 7'b0010011;
            2:       opcode = 7'b0110111;   // lui
            3:       opcode = 7'b0010111;   // auipc
            4:       opcode = 7'b0000011;
            5:       opcode = 7'b0100011;
            6:       opcode = 7'b1100011;
            7:       opcode = 7'b1101111;
            8:       opcode = 7'b1100111;
            9:       opcode = 7'b1110011;
            10:      opcode = 7'b0001111;   // fence
            11:      opcode = 7'b0000111;   // fp load is outside rv32ic
            default: opcode = 7'b1010011;
        endcase
        return {bits[31:7], opcode};
    endfunction

    function automatic logic [15:0] compressed_encoding();
        logic [15:0] bits;
        bits = $urandom();
        if ($urandom() % 12 == 0)
            return 16'h0000;
        return {bits[15:2], 2'($urandom() % 3)};
    endfunction

    task automatic build_image();
        int          h;
        logic [31:0] word;
        h = 0;
        while (h < image_halves)
        begin
            if (h < 64 || $urandom() % 2 == 0)   // first 32 words are aligned full-length code
            begin
                word = full_encoding();
                halves[h] = word[15:0];
                if (h + 1 < image_halves)
                    halves[h + 1] = word[31:16];
                h = h + 2;
            end
            else
            begin
                halves[h] = compressed_encoding();
                h = h + 1;
            end
        end
        for (int w = 0; w < image_halves / 2; w++)
            image[w] = {halves[2 * w + 1], halves[2 * w]};
    endtask

    function automatic rv_instr_pkg::instr_class_t expected_class(input logic [31:0] instr);
        logic [4:0] op;
        logic [2:0] f3;
        logic [1:0] quad;
        op = instr[6:2];
        f3 = instr[15:13];
        quad = instr[1:0];
        if (quad == 2'b11)
        begin
            if (op == 5'b01100 || op == 5'b00100 || op == 5'b01101 || op == 5'b00101)
                return rv_instr_pkg::cls_alu;
            if (op == 5'b00000)
                return rv_instr_pkg::cls_load;
            if (op == 5'b01000)
                return rv_instr_pkg::cls_store;
            if (op == 5'b11000)
                return rv_instr_pkg::cls_branch;
            if (op == 5'b11011 || op == 5'b11001)
                return rv_instr_pkg::cls_jump;
            if (op == 5'b11100 || op == 5'b00011)
                return rv_instr_pkg::cls_system;
            return rv_instr_pkg::cls_illegal;
        end
        if (instr[15:0] == 16'h0000)
            return rv_instr_pkg::cls_illegal;
        if (f3 == 3'b010 && quad != 2'b01)
            return rv_instr_pkg::cls_load;       // c.lw, c.lwsp
        if (f3 == 3'b110 && quad != 2'b01)
            return rv_instr_pkg::cls_store;
        if (quad == 2'b01)
        begin
            if (f3 == 3'b001 || f3 == 3'b101)
                return rv_instr_pkg::cls_jump;
            if (f3 == 3'b110 || f3 == 3'b111)
                return rv_instr_pkg::cls_branch;
            return rv_instr_pkg::cls_alu;
        end
        if (f3 == 3'b000)
            return rv_instr_pkg::cls_alu;        // c.addi4spn, c.slli
        if (quad == 2'b10 && f3 == 3'b100)
        begin
            if (instr[6:2] != 5'd0)
                return rv_instr_pkg::cls_alu;
            if (instr[12] && instr[11:7] == 5'd0)
                return rv_instr_pkg::cls_system; // c.ebreak
            return rv_instr_pkg::cls_jump;
        end
        return rv_instr_pkg::cls_illegal;
    endfunction

    task automatic check_record();
        logic [15:0] lo;
        logic [15:0] hi;
        logic        comp;
        logic [31:0] instr;
        lo = halves[exp_pc[9:1]];
        hi = halves[exp_pc[9:1] + 9'd1];        // image wraps at 1 KiB
        comp = (lo[1:0] != 2'b11);
        instr = comp ? {16'h0000, lo} : {hi, lo};
        check_value("record pc", rec.pc, exp_pc);
        check_value("record instruction", rec.instr, instr);
        check_value("compressed flag", rec.compressed, comp);
        check_value("instruction class", rec.cls, expected_class(instr));
        if (comp && lo == 16'h0000)
            zero_halves++;
        if (!comp && exp_pc[1])
            straddles++;
        exp_pc = exp_pc + (comp ? 2 : 4);
        received++;
    endtask

    task automatic plan_inputs();
        next_redirect = 1'b0;
        if (stall_left > 0)
        begin
            next_take = 1'b0;
            stall_left--;
        end
        else if ($urandom() % 150 == 0)
        begin
            stall_left = 30 + $urandom() % 16;  // long enough to fill the queue
            next_take = 1'b0;
        end
        else
            next_take = ($urandom() % 8 != 0);
        if (received >= 40 && !redirect && $urandom() % 120 == 0)
        begin
            next_redirect = 1'b1;
            next_redirect_pc = 32'(($urandom() % image_halves) * 2);
        end
    endtask

    task automatic sample_cycle();
        next_ack = (bus_req.cyc === 1'b1);      // memory answers one cycle later
        next_data = next_ack ? image[bus_req.addr[9:2]] : 32'h0;
        if (!reset_n)
        begin
            check_value("cyc during reset", bus_req.cyc, 0);
            check_value("valid during reset", valid, 0);
            return;
        end
        if (valid)
            check_record();
        if (redirect)
        begin
            exp_pc = redirect_pc;
            redirects++;
            take_low_run = 0;
        end
        else if (!take)
            take_low_run++;
        else
            take_low_run = 0;
        if (take_low_run >= 24)
        begin
            check_value("cyc with queue full", bus_req.cyc, 0);
            idle_checks++;
        end
        plan_inputs();
    endtask

    initial
    begin
        void'($urandom(77146));
        reset_n = 1'b0;
        redirect = 1'b0;
        redirect_pc = '0;
        take = 1'b0;
        bus_rsp = '0;
        next_ack = 1'b0;
        next_data = '0;
        next_take = 1'b0;
        next_redirect = 1'b0;
        next_redirect_pc = '0;
        exp_pc = `RV_RESET_PC;
        build_image();
        for (int edge_no = 1; received < num_records; edge_no++)
        begin
            @(posedge clk);
            #1;
            reset_n = (edge_no >= 16);
            bus_rsp.ack = next_ack;
            bus_rsp.data = next_data;
            take = next_take;
            redirect = next_redirect;
            redirect_pc = next_redirect_pc;
            @(negedge clk);
            sample_cycle();
        end
        check_value("straddling records seen", straddles != 0, 1);
        check_value("all-zero compressed records seen", zero_halves != 0, 1);
        check_value("redirects taken", redirects != 0, 1);
        check_value("idle bus checks under back-pressure", idle_checks != 0, 1);
        $display("No errors");
        $finish;
    end

endmodule

//--- tb.f
+incdir+.
rv_bus_pkg.sv
rv_instr_pkg.sv
rv_pc_gen.sv
rv_fetch_aligner.sv
rv_fetch_queue.sv
rv_predecode.sv
rv_fetch_top.sv
tb_rv_fetch.sv
